// ==== Makefile ====
SIM := obj_dir/Vmult_unit_tb

.PHONY: all run clean

all: $(SIM)

# rebuilt only when the file list or a source changes
$(SIM): compile.f $(wildcard src/*.sv verif/*.sv)
	verilator --binary --timing --assert --top-module mult_unit_tb \
		-f compile.f -o Vmult_unit_tb

# the run passes only if the pass line shows up in the output
run: $(SIM)
	./$(SIM) | tee /dev/stderr | grep -qx 'sim passed'

clean:
	rm -rf obj_dir

// ==== compile.f ====
src/mult_pkg.sv
src/mult_operand_prep.sv
src/mult_stage.sv
src/mult_pipeline.sv
src/mult_tag_pipe.sv
src/mult_ctrl.sv
src/mult_unit.sv
verif/mult_unit_props.sv
verif/mult_unit_tb.sv

// ==== src/mult_ctrl.sv ====
`timescale 1ns/1ps

module mult_ctrl (
    input  logic clock,
    input  logic reset,
    input  logic issue_valid,
    input  logic stall,
    output logic advance,
    output logic busy,
    output logic result_valid
);
    import mult_pkg::*;

    // bit i set when stage i holds a live multiply
    logic [MULT_STAGES-1:0] valid_q;

    // the whole pipe freezes together while the CDB arbiter stalls us
    assign advance = ~stall;

    always_ff @(posedge clock) begin
        if (reset) begin
            valid_q <= '0;
        end else if (advance) begin
            valid_q <= {valid_q[MULT_STAGES-2:0], issue_valid};
        end
    end

    assign busy = |valid_q;

    // result held in the last stage is not offered while stalled
    assign result_valid = valid_q[MULT_STAGES-1] & advance;

endmodule

// ==== src/mult_operand_prep.sv ====
`timescale 1ns/1ps

module mult_operand_prep (
    input  mult_pkg::funct3_t funct3,
    input  mult_pkg::word_t   rs1_value,
    input  mult_pkg::word_t   rs2_value,
    output mult_pkg::prod_t   mcand,
    output mult_pkg::prod_t   mplier
);
    import mult_pkg::*;

    // rs1 is the multiplicand, only MULHU treats it as unsigned
    always_comb begin
        case (funct3)
            F3_MUL, F3_MULH, F3_MULHSU: mcand = {{XLEN{rs1_value[XLEN-1]}}, rs1_value};
            default:                    mcand = {{XLEN{1'b0}}, rs1_value};
        endcase
    end

    // rs2 is the multiplier, signed only for MUL and MULH
    always_comb begin
        case (funct3)
            F3_MUL, F3_MULH: mplier = {{XLEN{rs2_value[XLEN-1]}}, rs2_value};
            default:         mplier = {{XLEN{1'b0}}, rs2_value};
        endcase
    end

endmodule

// ==== src/mult_pipeline.sv ====
`timescale 1ns/1ps

module mult_pipeline (
    input  logic              clock,
    input  logic              advance,
    input  mult_pkg::prod_t   mcand,
    input  mult_pkg::prod_t   mplier,
    input  mult_pkg::funct3_t funct3,
    output mult_pkg::word_t   result
);
    import mult_pkg::*;

    // entry i feeds stage i, entry MULT_STAGES is the last stage's output
    prod_t   sum_chain    [MULT_STAGES+1];
    prod_t   mcand_chain  [MULT_STAGES+1];
    prod_t   mplier_chain [MULT_STAGES+1];
    funct3_t funct3_chain [MULT_STAGES+1];
    prod_t   product;

    assign sum_chain[0]    = '0;  // running sum starts empty
    assign mcand_chain[0]  = mcand;
    assign mplier_chain[0] = mplier;
    assign funct3_chain[0] = funct3;

    for (genvar i = 0; i < MULT_STAGES; i++) begin : gen_stage
        mult_stage u_stage (
            .clock       (clock),
            .advance     (advance),
            .prev_sum    (sum_chain[i]),
            .mcand       (mcand_chain[i]),
            .mplier      (mplier_chain[i]),
            .funct3      (funct3_chain[i]),
            .product_sum (sum_chain[i+1]),
            .next_mcand  (mcand_chain[i+1]),
            .next_mplier (mplier_chain[i+1]),
            .next_funct3 (funct3_chain[i+1])
        );
    end

    assign product = sum_chain[MULT_STAGES];

    // funct3 rode along with the sum, so it matches this product
    assign result = (funct3_chain[MULT_STAGES] == F3_MUL) ? product[XLEN-1:0]
                                                          : product[PROD_WIDTH-1:XLEN];

endmodule

// ==== src/mult_pkg.sv ====
package mult_pkg;

    // architectural and internal widths
    localparam int XLEN        = 32;
    localparam int PROD_WIDTH  = 64;   // sign/zero extended operands and full product
    localparam int TAG_WIDTH   = 6;

    // pipeline depth, 2 and 8 also divide the product width evenly
    localparam int MULT_STAGES = 4;
    localparam int STAGE_SHIFT = PROD_WIDTH / MULT_STAGES;  // multiplier bits eaten per stage

    typedef logic [XLEN-1:0]       word_t;   // one register value
    typedef logic [PROD_WIDTH-1:0] prod_t;   // extended operand or running sum
    typedef logic [2:0]            funct3_t;
    typedef logic [TAG_WIDTH-1:0]  tag_t;    // physical destination register

    // RV32M multiply encodings of funct3
    localparam funct3_t F3_MUL    = 3'd0;  // low word, signed x signed
    localparam funct3_t F3_MULH   = 3'd1;  // high word, signed x signed
    localparam funct3_t F3_MULHSU = 3'd2;  // high word, signed x unsigned
    localparam funct3_t F3_MULHU  = 3'd3;  // high word, unsigned x unsigned

endpackage

// ==== src/mult_stage.sv ====
`timescale 1ns/1ps

module mult_stage (
    input  logic              clock,
    input  logic              advance,
    input  mult_pkg::prod_t   prev_sum,
    input  mult_pkg::prod_t   mcand,
    input  mult_pkg::prod_t   mplier,
    input  mult_pkg::funct3_t funct3,
    output mult_pkg::prod_t   product_sum,
    output mult_pkg::prod_t   next_mcand,
    output mult_pkg::prod_t   next_mplier,
    output mult_pkg::funct3_t next_funct3
);
    import mult_pkg::*;

    prod_t partial_product;

    // low multiplier chunk taken as unsigned, the extension above it carries the sign
    assign partial_product = prod_t'(mplier[STAGE_SHIFT-1:0]) * mcand;

    // no reset here, the valid chain in mult_ctrl qualifies these registers
    always_ff @(posedge clock) begin
        if (advance) begin
            product_sum <= prev_sum + partial_product;
            next_mplier <= mplier >> STAGE_SHIFT;  // drop the chunk just used
            next_mcand  <= mcand << STAGE_SHIFT;   // weight of the next chunk
            next_funct3 <= funct3;
        end
    end

endmodule

// ==== src/mult_tag_pipe.sv ====
`timescale 1ns/1ps

module mult_tag_pipe (
    input  logic           clock,
    input  logic           advance,
    input  mult_pkg::tag_t dest_tag,
    output mult_pkg::tag_t result_tag
);
    import mult_pkg::*;

    // one tag register per multiply stage
    tag_t tag_q [MULT_STAGES];

    // moves in lockstep with mult_pipeline, no reset since valid bits qualify the tags
    always_ff @(posedge clock) begin
        if (advance) begin
            tag_q[0] <= dest_tag;
            for (int i = 1; i < MULT_STAGES; i++) begin
                tag_q[i] <= tag_q[i-1];
            end
        end
    end

    assign result_tag = tag_q[MULT_STAGES-1];  // tag of the product leaving the last stage

endmodule

// ==== src/mult_unit.sv ====
`timescale 1ns/1ps

module mult_unit (
    input  logic              clock,
    input  logic              reset,
    input  logic              issue_valid,
    input  mult_pkg::funct3_t funct3,
    input  mult_pkg::word_t   rs1_value,
    input  mult_pkg::word_t   rs2_value,
    input  mult_pkg::tag_t    dest_tag,
    input  logic              stall,
    output logic              result_valid,
    output mult_pkg::word_t   result,
    output mult_pkg::tag_t    result_tag,
    output logic              busy
);
    import mult_pkg::*;

    logic  advance;  // shared enable for every stage register
    prod_t mcand;
    prod_t mplier;

    mult_ctrl u_ctrl (
        .clock        (clock),
        .reset        (reset),
        .issue_valid  (issue_valid),
        .stall        (stall),
        .advance      (advance),
        .busy         (busy),
        .result_valid (result_valid)
    );

    // extension happens before the first stage register
    mult_operand_prep u_prep (
        .funct3    (funct3),
        .rs1_value (rs1_value),
        .rs2_value (rs2_value),
        .mcand     (mcand),
        .mplier    (mplier)
    );

    mult_pipeline u_pipeline (
        .clock   (clock),
        .advance (advance),
        .mcand   (mcand),
        .mplier  (mplier),
        .funct3  (funct3),
        .result  (result)
    );

    // same depth and enable as the datapath so the tag lines up with its product
    mult_tag_pipe u_tag_pipe (
        .clock      (clock),
        .advance    (advance),
        .dest_tag   (dest_tag),
        .result_tag (result_tag)
    );

endmodule

// ==== verif/mult_unit_props.sv ====
`timescale 1ns/1ps

module mult_unit_props (
    input logic            clock,
    input logic            reset,
    input logic            issue_valid,
    input logic            stall,
    input logic            result_valid,
    input mult_pkg::word_t result,
    input mult_pkg::tag_t  result_tag,
    input logic            busy
);
    import mult_pkg::*;

    int unsigned advance_count;       // edges on which the pipe moved
    int unsigned issue_time [16];     // advance_count at each issue, in issue order
    logic [3:0]  wr_ptr;
    logic [3:0]  rd_ptr;
    int          pending;             // issued and not yet returned
    int          assert_failures = 0;

    always @(posedge clock) begin
        if (reset) begin
            advance_count <= 0;
            wr_ptr        <= '0;
            rd_ptr        <= '0;
            pending       <= 0;
        end else begin
            if (!stall) advance_count <= advance_count + 1;
            if (issue_valid && !stall) begin
                issue_time[wr_ptr] <= advance_count;
                wr_ptr             <= wr_ptr + 4'd1;
            end
            if (result_valid) rd_ptr <= rd_ptr + 4'd1;
            pending <= pending + int'(issue_valid && !stall) - int'(result_valid);
        end
    end

    // stalled cycles do not count toward the latency
    latency_check: assert property (@(posedge clock) disable iff (reset)
        result_valid |-> pending != 0 && (advance_count - issue_time[rd_ptr]) == MULT_STAGES)
        else begin
            assert_failures = assert_failures + 1;
            $error("result_valid did not arrive MULT_STAGES advancing cycles after its issue");
        end

    stall_blocks_result: assert property (@(posedge clock) disable iff (reset)
        stall |-> !result_valid)
        else begin
            assert_failures = assert_failures + 1;
            $error("result_valid was high while stall was high");
        end

    stall_holds_output: assert property (@(posedge clock) disable iff (reset)
        stall |=> $stable(result) && $stable(result_tag))
        else begin
            assert_failures = assert_failures + 1;
            $error("result or result_tag changed across a stalled edge");
        end

    busy_tracks_pending: assert property (@(posedge clock) disable iff (reset)
        busy == (pending != 0))
        else begin
            assert_failures = assert_failures + 1;
            $error("busy does not match the number of outstanding multiplies");
        end

    // first cycle out of reset
    quiet_after_reset: assert property (@(posedge clock)
        $fell(reset) |-> !result_valid && !busy)
        else begin
            assert_failures = assert_failures + 1;
            $error("result_valid or busy high right after reset release");
        end

endmodule

// ==== verif/mult_unit_tb.sv ====
`timescale 1ns/1ps

module mult_unit_tb;
    import mult_pkg::*;

    localparam int NUM_MULTS    = 200;
    localparam int CLOCK_PERIOD = 8;

    logic    clock;
    logic    reset;
    logic    issue_valid;
    funct3_t funct3;
    word_t   rs1_value;
    word_t   rs2_value;
    tag_t    dest_tag;
    logic    stall;
    logic    result_valid;
    word_t   result;
    tag_t    result_tag;
    logic    busy;

    word_t expected_result_q [$];  // one entry per outstanding multiply, oldest first
    tag_t  expected_tag_q [$];

    mult_unit uut (
        .clock        (clock),
        .reset        (reset),
        .issue_valid  (issue_valid),
        .funct3       (funct3),
        .rs1_value    (rs1_value),
        .rs2_value    (rs2_value),
        .dest_tag     (dest_tag),
        .stall        (stall),
        .result_valid (result_valid),
        .result       (result),
        .result_tag   (result_tag),
        .busy         (busy)
    );

    bind mult_unit mult_unit_props props (
        .clock        (clock),
        .reset        (reset),
        .issue_valid  (issue_valid),
        .stall        (stall),
        .result_valid (result_valid),
        .result       (result),
        .result_tag   (result_tag),
        .busy         (busy)
    );

    initial begin
        clock = 1'b0;
        forever #(CLOCK_PERIOD / 2) clock = ~clock;
    end

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("sim failed");
        $fatal(1);
    endtask

    // extend both sources to 64 bits, multiply, keep the half the opcode asks for
    function automatic word_t product_half(funct3_t f, word_t a, word_t b);
        logic [2*XLEN-1:0] ext_a;
        logic [2*XLEN-1:0] ext_b;
        logic [2*XLEN-1:0] full;
        ext_a = (f == F3_MULHU) ? {{XLEN{1'b0}}, a} : {{XLEN{a[XLEN-1]}}, a};
        ext_b = (f == F3_MUL || f == F3_MULH) ? {{XLEN{b[XLEN-1]}}, b} : {{XLEN{1'b0}}, b};
        full  = ext_a * ext_b;
        return (f == F3_MUL) ? full[XLEN-1:0] : full[2*XLEN-1:XLEN];
    endfunction

    // corner values show up often, the rest are uniform
    function automatic word_t pick_operand();
        case ($urandom_range(0, 7))
            0:       return '0;
            1:       return '1;
            2:       return {1'b1, {(XLEN-1){1'b0}}};
            3:       return {1'b0, {(XLEN-1){1'b1}}};
            4:       return word_t'(1);
            default: return word_t'($urandom);
        endcase
    endfunction

    task automatic issue_multiply();
        funct3_t f;
        word_t   a;
        word_t   b;
        tag_t    t;
        f = funct3_t'($urandom_range(0, 3));
        a = pick_operand();
        b = pick_operand();
        t = tag_t'($urandom);
        issue_valid = 1'b1;
        funct3      = f;
        rs1_value   = a;
        rs2_value   = b;
        dest_tag    = t;
        expected_result_q.push_back(product_half(f, a, b));
        expected_tag_q.push_back(t);
    endtask

    always @(posedge clock) begin : check_results
        word_t exp_result;
        tag_t  exp_tag;
        if (!reset && result_valid) begin
            if (expected_result_q.size() == 0) begin
                report_failure("result_valid seen with no multiply outstanding");
            end
            exp_result = expected_result_q.pop_front();
            exp_tag    = expected_tag_q.pop_front();
            assert (result === exp_result)
                else report_failure($sformatf("FAILED result: got %h expected %h",
                                              result, exp_result));
            assert (result_tag === exp_tag)
                else report_failure($sformatf("FAILED result_tag: got %h expected %h",
                                              result_tag, exp_tag));
        end
    end

    always @(negedge clock) begin
        if (uut.props.assert_failures != 0) begin
            report_failure("a timing assertion on mult_unit failed");
        end
    end

    initial begin
        #(NUM_MULTS * (MULT_STAGES + 4) * CLOCK_PERIOD);
        $display("timeout, the multiplies did not all complete in the allowed time");
        $display("sim failed");
        $fatal(1);
    end

    initial begin
        int issued;
        int stall_left;
        void'($urandom(56));
        reset       = 1'b1;
        issue_valid = 1'b1;  // multiplies offered during reset must not survive it
        funct3      = F3_MUL;
        rs1_value   = '0;
        rs2_value   = '0;
        dest_tag    = '0;
        stall       = 1'b0;
        issued      = 0;
        stall_left  = 0;
        repeat (3) @(posedge clock);
        @(negedge clock);
        reset       = 1'b0;
        issue_valid = 1'b0;
        repeat (2) @(negedge clock);  // let the datapath fill with defined values

        while (issued < NUM_MULTS) begin
            @(negedge clock);
            issue_valid = 1'b0;
            if (stall_left > 0) begin
                stall = 1'b1;
                stall_left--;
            end else if ($urandom_range(0, 9) == 0) begin
                stall      = 1'b1;  // stall bursts of 1 to 4 cycles
                stall_left = int'($urandom_range(0, 3));
            end else begin
                stall = 1'b0;
                if ($urandom_range(0, 3) != 0) begin
                    issue_multiply();
                    issued++;
                end
            end
        end

        @(negedge clock);
        issue_valid = 1'b0;
        stall       = 1'b0;
        while (busy) @(negedge clock);
        @(negedge clock);

        if (expected_result_q.size() != 0 || uut.props.assert_failures != 0) begin
            if (expected_result_q.size() != 0) begin
                $display("%0d multiplies never returned a result", expected_result_q.size());
            end else begin
                $display("%0d timing assertions failed", uut.props.assert_failures);
            end
            $display("sim failed");
            $fatal(1);
        end else begin
            $display("sim passed");
            $finish;
        end
    end

endmodule
